//--- hw/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN      32
`define RV_MEM_WORDS 1024
`define RV_MEM_AW    10

`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

`define RV_F3_ADDI  3'b000
`define RV_F3_SLTIU 3'b011
`define RV_F3_SLLI  3'b001
`define RV_F3_ADD   3'b000
`define RV_F3_JALR  3'b000
`define RV_F3_BEQ   3'b000
`define RV_F3_BNE   3'b001
`define RV_F3_BGE   3'b101
`define RV_F3_LW    3'b010
`define RV_F3_SB    3'b000
`define RV_F3_SH    3'b001
`define RV_F3_SW    3'b010

`endif

//--- hw/rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;

	typedef logic [4:0] reg_idx_t;

	typedef logic [3:0] byte_mask_t; // one bit per byte lane

	typedef logic [`RV_MEM_AW-1:0] mem_addr_t; // word index

	typedef enum logic [1:0] {
		FETCH,
		WAIT_I,
		EXEC,
		MEM
	} core_state_e;

endpackage

`default_nettype wire

//--- hw/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if;
	import rv_pkg::*;

	logic req;
	logic we;
	word_t addr; // byte address
	word_t wdata;
	byte_mask_t wmask;
	logic gnt;
	word_t rdata; // valid cycle after gnt

	modport requester (
		output req, we, addr, wdata, wmask,
		input gnt, rdata
	);

	modport arbiter (
		input req, we, addr, wdata, wmask,
		output gnt, rdata
	);

endinterface

`default_nettype wire

//--- hw/exu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module exu (
	input logic [6:0] opcode,
	input logic [2:0] funct3,
	input logic [6:0] funct7,
	input rv_pkg::word_t src1,
	input rv_pkg::word_t src2,
	input rv_pkg::word_t imm,
	input rv_pkg::word_t pc,
	output rv_pkg::word_t val,
	output logic jump_taken,
	output rv_pkg::word_t jump_target,
	output logic mem_en,
	output logic mem_we,
	output rv_pkg::word_t mem_addr,
	output rv_pkg::byte_mask_t wmask
);

	always_comb begin
		val = '0;
		case (opcode)
			`RV_OP_LUI: val = imm;
			`RV_OP_AUIPC: val = pc + imm;
			`RV_OP_JAL: val = pc + 32'd4;
			`RV_OP_JALR: val = (funct3 == `RV_F3_JALR) ? pc + 32'd4 : '0;
			`RV_OP_IMM: begin
				if (funct3 == `RV_F3_ADDI)
					val = src1 + imm;
				else if (funct3 == `RV_F3_SLTIU)
					val = {31'b0, src1 < imm}; // unsigned compare
				else if (funct3 == `RV_F3_SLLI && funct7 == 7'b0)
					val = src1 << imm[4:0];
			end
			`RV_OP_REG: begin
				if (funct3 == `RV_F3_ADD && funct7 == 7'b0)
					val = src1 + src2;
			end
			default: val = '0;
		endcase
	end

	always_comb begin
		jump_taken = 1'b0;
		jump_target = pc + imm; // jal and branches
		case (opcode)
			`RV_OP_JAL: jump_taken = 1'b1;
			`RV_OP_JALR: begin
				jump_taken = (funct3 == `RV_F3_JALR);
				jump_target = (src1 + imm) & ~32'd1;
			end
			`RV_OP_BRANCH: begin
				case (funct3)
					`RV_F3_BEQ: jump_taken = (src1 == src2);
					`RV_F3_BNE: jump_taken = (src1 != src2);
					`RV_F3_BGE: jump_taken = ($signed(src1) >= $signed(src2));
					default: jump_taken = 1'b0;
				endcase
			end
			default: jump_taken = 1'b0;
		endcase
	end

	always_comb begin
		case (funct3)
			`RV_F3_SB: wmask = 4'h1;
			`RV_F3_SH: wmask = 4'h3;
			`RV_F3_SW: wmask = 4'hf;
			default: wmask = 4'h0;
		endcase
		if (opcode != `RV_OP_STORE)
			wmask = 4'h0;
	end

	assign mem_we = (opcode == `RV_OP_STORE) && (wmask != 4'h0);
	assign mem_en = mem_we || (opcode == `RV_OP_LOAD && funct3 == `RV_F3_LW); // lw only
	assign mem_addr = src1 + imm;

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input logic clk,
	input logic arst_n,
	input rv_pkg::reg_idx_t rs1,
	input rv_pkg::reg_idx_t rs2,
	output rv_pkg::word_t rdata1,
	output rv_pkg::word_t rdata2,
	input logic we,
	input rv_pkg::reg_idx_t rd,
	input rv_pkg::word_t wdata
);
	import rv_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin // x0 never written
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = regs[rs1];
	assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

//--- hw/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic we,
	input rv_pkg::word_t addr,
	input rv_pkg::word_t store_data,
	input rv_pkg::byte_mask_t mask,
	output logic done,
	output rv_pkg::word_t load_data,
	mem_if.requester bus
);
	import rv_pkg::*;

	logic pending;
	logic we_q;
	word_t addr_q;
	word_t data_q;
	byte_mask_t mask_q;
	logic cur_we;
	word_t cur_addr;
	word_t cur_data;
	byte_mask_t cur_mask;
	logic [1:0] lane;

	// start cycle uses live inputs, later cycles the held copy
	assign cur_we = pending ? we_q : we;
	assign cur_addr = pending ? addr_q : addr;
	assign cur_data = pending ? data_q : store_data;
	assign cur_mask = pending ? mask_q : mask;
	assign lane = cur_addr[1:0];

	assign bus.req = start | pending;
	assign bus.we = cur_we;
	assign bus.addr = cur_addr;
	assign bus.wdata = cur_data << {lane, 3'b000}; // byte lane placement
	assign bus.wmask = cur_we ? byte_mask_t'(cur_mask << lane) : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= bus.req && bus.gnt;
			if (bus.req && bus.gnt)
				pending <= 1'b0;
			else if (start)
				pending <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			we_q <= we;
			addr_q <= addr;
			data_q <= store_data;
			mask_q <= mask;
		end
	end

	assign load_data = bus.rdata; // routed only after our grant

endmodule

`default_nettype wire

//--- hw/core_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module core_ctrl (
	input logic clk,
	input logic arst_n,
	input logic run,
	mem_if.requester fetch_bus,
	mem_if.requester data_bus,
	output logic retire,
	output rv_pkg::word_t retire_pc,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t retire_data
);
	import rv_pkg::*;

	core_state_e state;
	word_t pc;
	word_t ir;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t rd;
	word_t imm;
	word_t src1;
	word_t src2;
	word_t exu_val;
	logic jump_taken;
	word_t jump_target;
	logic mem_en;
	logic mem_we;
	word_t mem_addr;
	byte_mask_t wmask;
	logic lsu_done;
	word_t load_data;
	logic wb_en;
	word_t wb_data;

	assign opcode = ir[6:0];
	assign rd = ir[11:7];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];

	always_comb begin
		case (opcode)
			`RV_OP_LUI, `RV_OP_AUIPC: imm = {ir[31:12], 12'b0};
			`RV_OP_JAL: imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			`RV_OP_BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			`RV_OP_STORE: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			default: imm = {{20{ir[31]}}, ir[31:20]}; // I type
		endcase
	end

	always_comb begin
		case (opcode)
			`RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL: wb_en = 1'b1;
			`RV_OP_JALR: wb_en = (funct3 == `RV_F3_JALR);
			`RV_OP_LOAD: wb_en = (funct3 == `RV_F3_LW);
			`RV_OP_IMM: wb_en = (funct3 == `RV_F3_ADDI) || (funct3 == `RV_F3_SLTIU) ||
					(funct3 == `RV_F3_SLLI && funct7 == 7'b0);
			`RV_OP_REG: wb_en = (funct3 == `RV_F3_ADD) && (funct7 == 7'b0);
			default: wb_en = 1'b0; // unsupported, no effect
		endcase
	end

	assign wb_data = (opcode == `RV_OP_LOAD) ? load_data : exu_val;
	assign retire = ((state == EXEC) && !mem_en) || ((state == MEM) && lsu_done);
	assign retire_pc = pc;
	assign retire_rd = wb_en ? rd : 5'd0;
	assign retire_data = wb_en ? wb_data : '0;

	assign fetch_bus.req = (state == FETCH) && run;
	assign fetch_bus.we = 1'b0;
	assign fetch_bus.addr = pc;
	assign fetch_bus.wdata = '0;
	assign fetch_bus.wmask = '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= FETCH;
			pc <= '0;
		end else begin
			case (state)
				FETCH: begin
					if (fetch_bus.req && fetch_bus.gnt)
						state <= WAIT_I;
				end
				WAIT_I: state <= EXEC;
				EXEC: state <= mem_en ? MEM : FETCH;
				MEM: begin
					if (lsu_done)
						state <= FETCH;
				end
				default: state <= FETCH;
			endcase
			if (retire)
				pc <= jump_taken ? jump_target : pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (state == WAIT_I)
			ir <= fetch_bus.rdata;
	end

	exu u_exu (
		.opcode(opcode), .funct3(funct3), .funct7(funct7),
		.src1(src1), .src2(src2), .imm(imm), .pc(pc),
		.val(exu_val), .jump_taken(jump_taken), .jump_target(jump_target),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .wmask(wmask)
	);

	regfile u_regfile (
		.clk(clk), .arst_n(arst_n),
		.rs1(ir[19:15]), .rs2(ir[24:20]), .rdata1(src1), .rdata2(src2),
		.we(retire && wb_en), .rd(rd), .wdata(wb_data)
	);

	lsu u_lsu (
		.clk(clk), .arst_n(arst_n),
		.start((state == EXEC) && mem_en), .we(mem_we), .addr(mem_addr),
		.store_data(src2), .mask(wmask),
		.done(lsu_done), .load_data(load_data), .bus(data_bus)
	);

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module mem_arbiter (
	input logic clk,
	input logic arst_n,
	mem_if.arbiter load_bus,
	mem_if.arbiter data_bus,
	mem_if.arbiter fetch_bus,
	output logic mem_en,
	output logic mem_we,
	output rv_pkg::mem_addr_t mem_addr,
	output rv_pkg::word_t mem_wdata,
	output rv_pkg::byte_mask_t mem_wmask,
	input rv_pkg::word_t mem_rdata
);
	import rv_pkg::*;

	logic [2:0] owner_q; // {load, data, fetch}
	word_t sel_addr;

	assign load_bus.gnt = load_bus.req;
	assign data_bus.gnt = data_bus.req && !load_bus.req;
	assign fetch_bus.gnt = fetch_bus.req && !load_bus.req && !data_bus.req;

	always_comb begin
		mem_we = fetch_bus.we;
		sel_addr = fetch_bus.addr;
		mem_wdata = fetch_bus.wdata;
		mem_wmask = fetch_bus.wmask;
		if (load_bus.req) begin
			mem_we = load_bus.we;
			sel_addr = load_bus.addr;
			mem_wdata = load_bus.wdata;
			mem_wmask = load_bus.wmask;
		end else if (data_bus.req) begin
			mem_we = data_bus.we;
			sel_addr = data_bus.addr;
			mem_wdata = data_bus.wdata;
			mem_wmask = data_bus.wmask;
		end
	end

	assign mem_en = load_bus.req || data_bus.req || fetch_bus.req;
	assign mem_addr = sel_addr[`RV_MEM_AW+1:2]; // byte to word index

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			owner_q <= 3'b000;
		else
			owner_q <= {load_bus.gnt, data_bus.gnt, fetch_bus.gnt};
	end

	assign load_bus.rdata = owner_q[2] ? mem_rdata : '0;
	assign data_bus.rdata = owner_q[1] ? mem_rdata : '0;
	assign fetch_bus.rdata = owner_q[0] ? mem_rdata : '0;

endmodule

`default_nettype wire

//--- hw/unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module unified_mem (
	input logic clk,
	input logic en,
	input logic we,
	input rv_pkg::mem_addr_t addr,
	input rv_pkg::word_t wdata,
	input rv_pkg::byte_mask_t wmask,
	output rv_pkg::word_t rdata
);
	import rv_pkg::*;

	word_t mem [`RV_MEM_WORDS];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				for (int b = 0; b < 4; b++) begin
					if (wmask[b])
						mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
			rdata <= mem[addr]; // old data on a write
		end
	end

endmodule

`default_nettype wire

//--- hw/rv_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_top (
	input logic clk,
	input logic arst_n,
	input logic run,
	input logic load_en,
	input rv_pkg::word_t load_addr,
	input rv_pkg::word_t load_data,
	output logic retire,
	output rv_pkg::word_t retire_pc,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t retire_data
);
	import rv_pkg::*;

	logic mem_en;
	logic mem_we;
	mem_addr_t mem_addr;
	word_t mem_wdata;
	byte_mask_t mem_wmask;
	word_t mem_rdata;

	mem_if fetch_bus ();
	mem_if data_bus ();
	mem_if load_bus ();

	// program loader, full word writes
	assign load_bus.req = load_en;
	assign load_bus.we = 1'b1;
	assign load_bus.addr = load_addr;
	assign load_bus.wdata = load_data;
	assign load_bus.wmask = '1;

	core_ctrl u_core_ctrl (
		.clk(clk), .arst_n(arst_n), .run(run),
		.fetch_bus(fetch_bus.requester), .data_bus(data_bus.requester),
		.retire(retire), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

	mem_arbiter u_mem_arbiter (
		.clk(clk), .arst_n(arst_n),
		.load_bus(load_bus.arbiter), .data_bus(data_bus.arbiter),
		.fetch_bus(fetch_bus.arbiter),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_wmask(mem_wmask), .mem_rdata(mem_rdata)
	);

	unified_mem u_unified_mem (
		.clk(clk), .en(mem_en), .we(mem_we), .addr(mem_addr),
		.wdata(mem_wdata), .wmask(mem_wmask), .rdata(mem_rdata)
	);

endmodule

`default_nettype wire

//--- testbench/tb_rv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_rv_top;
	localparam int NUM_ROWS = 29;

	logic clk;
	logic arst_n;
	logic run;
	logic load_en;
	logic [31:0] load_addr;
	logic [31:0] load_data;
	logic retire;
	logic [31:0] retire_pc;
	logic [4:0] retire_rd;
	logic [31:0] retire_data;

	logic [31:0] row_instr [NUM_ROWS];
	logic [31:0] row_pc [NUM_ROWS];
	logic [31:0] row_rd [NUM_ROWS];
	logic [31:0] row_data [NUM_ROWS];
	bit row_retires [NUM_ROWS]; // 0 for words jumped over
	int n_rows = 0;

	rv_top u_rv_top (
		.clk(clk), .arst_n(arst_n), .run(run),
		.load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.retire(retire), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] r_type(input int rs2, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] op);
		return {7'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `RV_OP_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] op);
		return {imm[19:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] j_type(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OP_JAL};
	endfunction

	task automatic add_row(input logic [31:0] instr, input logic [31:0] pc, input int rd,
			input logic [31:0] data, input bit retires);
		row_instr[n_rows] = instr;
		row_pc[n_rows] = pc;
		row_rd[n_rows] = rd;
		row_data[n_rows] = data;
		row_retires[n_rows] = retires;
		n_rows++;
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %0d ns: %s expected %h, got %h", $time, what, expected, got);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic wait_retire(input int row);
		int cycles;
		bit seen;
		seen = 1'b0;
		for (cycles = 0; cycles < 20 && !seen; cycles++) begin
			@(negedge clk);
			seen = retire;
		end
		if (!seen) begin
			$display("no retirement within 20 cycles while waiting for row %0d", row);
			$display("Testbench failed");
			$fatal(1, "timeout");
		end
	endtask

	task automatic build_table();
		add_row(u_type('h12345, 1, `RV_OP_LUI), 32'h00, 1, 32'h12345000, 1);
		add_row(u_type(1, 2, `RV_OP_AUIPC), 32'h04, 2, 32'h00001004, 1);
		add_row(i_type(-5, 0, `RV_F3_ADDI, 3, `RV_OP_IMM), 32'h08, 3, 32'hfffffffb, 1);
		add_row(i_type(-1, 3, `RV_F3_SLTIU, 4, `RV_OP_IMM), 32'h0c, 4, 32'h1, 1);
		add_row(i_type(5, 3, `RV_F3_SLTIU, 5, `RV_OP_IMM), 32'h10, 5, 32'h0, 1);
		add_row(i_type(4, 3, `RV_F3_SLLI, 6, `RV_OP_IMM), 32'h14, 6, 32'hffffffb0, 1);
		add_row(r_type(2, 1, `RV_F3_ADD, 7, `RV_OP_REG), 32'h18, 7, 32'h12346004, 1);
		add_row(i_type('h100, 0, `RV_F3_ADDI, 8, `RV_OP_IMM), 32'h1c, 8, 32'h100, 1);
		add_row(s_type(0, 1, 8, `RV_F3_SW), 32'h20, 0, 32'h0, 1); // data word at 0x100
		add_row(s_type(1, 3, 8, `RV_F3_SB), 32'h24, 0, 32'h0, 1);
		add_row(s_type(2, 6, 8, `RV_F3_SH), 32'h28, 0, 32'h0, 1);
		add_row(i_type(0, 8, `RV_F3_LW, 9, `RV_OP_LOAD), 32'h2c, 9, 32'hffb0fb00, 1);
		add_row(b_type(8, 5, 4, `RV_F3_BEQ), 32'h30, 0, 32'h0, 1); // 1 vs 0, falls through
		add_row(b_type(8, 0, 5, `RV_F3_BEQ), 32'h34, 0, 32'h0, 1);
		add_row(i_type(1, 0, `RV_F3_ADDI, 10, `RV_OP_IMM), 32'h38, 10, 32'h1, 0);
		add_row(b_type(8, 0, 5, `RV_F3_BNE), 32'h3c, 0, 32'h0, 1);
		add_row(b_type(8, 4, 3, `RV_F3_BNE), 32'h40, 0, 32'h0, 1);
		add_row(i_type(1, 0, `RV_F3_ADDI, 10, `RV_OP_IMM), 32'h44, 10, 32'h1, 0);
		add_row(b_type(8, 4, 3, `RV_F3_BGE), 32'h48, 0, 32'h0, 1); // -5 >= 1 is false
		add_row(b_type(8, 3, 4, `RV_F3_BGE), 32'h4c, 0, 32'h0, 1);
		add_row(i_type(1, 0, `RV_F3_ADDI, 10, `RV_OP_IMM), 32'h50, 10, 32'h1, 0);
		add_row(j_type(8, 10), 32'h54, 10, 32'h58, 1);
		add_row(i_type(1, 0, `RV_F3_ADDI, 10, `RV_OP_IMM), 32'h58, 10, 32'h1, 0);
		add_row(i_type(100, 0, `RV_F3_ADDI, 11, `RV_OP_IMM), 32'h5c, 11, 32'h64, 1);
		add_row(i_type(5, 11, `RV_F3_JALR, 12, `RV_OP_JALR), 32'h60, 12, 32'h64, 1); // 105 -> 104
		add_row(i_type(1, 0, `RV_F3_ADDI, 10, `RV_OP_IMM), 32'h64, 10, 32'h1, 0);
		add_row(i_type(77, 0, `RV_F3_ADDI, 0, `RV_OP_IMM), 32'h68, 0, 32'h4d, 1);
		add_row(r_type(7, 0, `RV_F3_ADD, 13, `RV_OP_REG), 32'h6c, 13, 32'h12346004, 1);
		add_row(r_type(3, 13, `RV_F3_ADD, 14, `RV_OP_REG), 32'h70, 14, 32'h12345fff, 1);
	endtask

	initial begin
		int i;

		arst_n = 1'b0;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		build_table();

		for (i = 0; i < 16; i++) begin
			@(negedge clk);
			check_value("retire during reset", {31'b0, retire}, 32'h0);
		end
		@(posedge clk);
		#1 arst_n = 1'b1;

		// program load through the loader port
		for (i = 0; i < n_rows; i++) begin
			@(posedge clk);
			#1;
			load_en = 1'b1;
			load_addr = i * 4;
			load_data = row_instr[i];
			@(negedge clk);
			check_value("retire during load", {31'b0, retire}, 32'h0);
		end
		@(posedge clk);
		#1;
		load_en = 1'b0;
		run = 1'b1;

		for (i = 0; i < n_rows; i++) begin
			if (row_retires[i]) begin
				wait_retire(i);
				check_value("retire_pc", retire_pc, row_pc[i]);
				check_value("retire_rd", {27'b0, retire_rd}, row_rd[i]);
				check_value("retire_data", retire_data, row_data[i]);
			end
		end

		@(posedge clk);
		#1 run = 1'b0; // before the next fetch can be granted
		for (i = 0; i < 20; i++) begin
			@(negedge clk);
			check_value("retire after run low", {31'b0, retire}, 32'h0);
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/rv_pkg.sv
hw/mem_if.sv
hw/exu.sv
hw/regfile.sv
hw/lsu.sv
hw/core_ctrl.sv
hw/mem_arbiter.sv
hw/unified_mem.sv
hw/rv_top.sv
testbench/tb_rv_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_rv_top \
	--Mdir obj_dir -o tb_rv_top

./obj_dir/tb_rv_top
